// ==== hdl/buffer_write_if.sv ====
// Write port of the buffer; write_enable must never be raised while full is high
`timescale 1ns/10ps
`default_nettype none

interface buffer_write_if;

  // One-cycle write strobe from the arbiter
  logic write_enable;

  // Word to store, steered from the granted client
  ooo_pkg::data_t write_data;

  // Lowest free slot, valid combinationally in the same cycle
  ooo_pkg::index_t write_index;

  // Registered, high when every slot holds data
  logic full;

  // Arbiter side drives the strobe and data
  modport arbiter (
    output write_enable,
    output write_data,
    input  write_index,
    input  full
  );

  // Buffer side returns the slot and the full status
  modport buffer (
    input  write_enable,
    input  write_data,
    output write_index,
    output full
  );

endinterface

`default_nettype wire

// ==== hdl/free_slot_finder.sv ====
// Purely combinational; with no free slot the one-hot is zero and the index is zero
`timescale 1ns/10ps
`default_nettype none

`include "ooo_defs.svh"

module free_slot_finder (
  input  ooo_pkg::slot_mask_t valid,
  output ooo_pkg::slot_mask_t free_onehot,
  output ooo_pkg::index_t     free_index
);

  import ooo_pkg::*;

  // Free slots are the clear bits of the valid mask
  slot_mask_t free_mask;

  // Encoded index, built by OR of every set position
  index_t index_acc;

  assign free_mask = ~valid;

  // Two's complement trick
  // Keeps only the lowest set bit of the free mask
  assign free_onehot = free_mask & (~free_mask + slot_mask_t'(1));

  // One-hot to binary
  // At most one bit is set, so OR-ing the positions is exact
  always_comb begin
    index_acc = '0;
    for (int slot = 0; slot < `OOO_DEPTH; slot++) begin
      if (free_onehot[slot]) begin
        index_acc = index_acc | index_t'(slot);
      end
    end
  end

  // All-valid case falls out as index zero
  assign free_index = index_acc;

endmodule

`default_nettype wire

// ==== hdl/ooo_defs.svh ====
// Sizes for the tagged store; OOO_DEPTH must be a power of two and OOO_CLIENTS at least 1
`ifndef OOO_DEFS_SVH
`define OOO_DEFS_SVH

// Bits per stored data word
`define OOO_WIDTH 8

// Number of slots in the buffer
// Keep this a power of two so every index names a real slot
`define OOO_DEPTH 8

// Number of clients sharing the write port
`define OOO_CLIENTS 2

// Slot index width, derived
`define OOO_INDEX_BITS $clog2(`OOO_DEPTH)

`endif

// ==== hdl/ooo_pkg.sv ====
// Shared types only; sizes come from the macro header, which must be on the include path
`default_nettype none

`include "ooo_defs.svh"

package ooo_pkg;

  // One stored data word
  typedef logic [`OOO_WIDTH-1:0] data_t;

  // Slot number inside the buffer
  typedef logic [`OOO_INDEX_BITS-1:0] index_t;

  // One bit per slot
  // Used for valid masks and one-hot slot selects
  typedef logic [`OOO_DEPTH-1:0] slot_mask_t;

  // One bit per client, for requests and grants
  typedef logic [`OOO_CLIENTS-1:0] client_mask_t;

endpackage

`default_nettype wire

// ==== hdl/ooo_store_top.sv ====
// Top level; one write per cycle among the clients, one consumer, reads are combinational
`timescale 1ns/10ps
`default_nettype none

`include "ooo_defs.svh"

module ooo_store_top (
  input  logic                                    clock,
  input  logic                                    resetn,

  // Client side
  // Requests are levels, grants are one-cycle pulses
  input  ooo_pkg::client_mask_t                   write_request,
  input  ooo_pkg::data_t [`OOO_CLIENTS-1:0]       client_data,
  output ooo_pkg::client_mask_t                   write_grant,
  output ooo_pkg::index_t                         grant_index,

  // Consumer side
  input  logic                                    read_enable,
  input  logic                                    read_clear,
  input  ooo_pkg::index_t                         read_index,
  output ooo_pkg::data_t                          read_data,
  output logic                                    read_error,

  // Status, registered
  output logic                                    full,
  output logic                                    empty
);

  import ooo_pkg::*;

  // Write port between arbiter and buffer
  buffer_write_if write_bus ();

  // Round-robin choice of the writing client
  write_arbiter arbiter (
    .clock         ( clock                   ),
    .resetn        ( resetn                  ),
    .write_request ( write_request           ),
    .client_data   ( client_data             ),
    .write_grant   ( write_grant             ),
    .grant_index   ( grant_index             ),
    .wr            ( write_bus.arbiter       )
  );

  // Slot store with allocate-on-write and read-with-clear
  out_of_order_buffer buffer (
    .clock         ( clock                   ),
    .resetn        ( resetn                  ),
    .wr            ( write_bus.buffer        ),
    .read_enable   ( read_enable             ),
    .read_clear    ( read_clear              ),
    .read_index    ( read_index              ),
    .read_data     ( read_data               ),
    .read_error    ( read_error              ),
    .empty         ( empty                   )
  );

  // Full lives on the write port, brought out for the clients
  assign full = write_bus.full;

endmodule

`default_nettype wire

// ==== hdl/out_of_order_buffer.sv ====
// Assumes one write port and one consumer and never resets stored data words
`timescale 1ns/10ps
`default_nettype none

`include "ooo_defs.svh"

module out_of_order_buffer (
  input  logic                clock,
  input  logic                resetn,
  buffer_write_if.buffer      wr,
  input  logic                read_enable,
  input  logic                read_clear,
  input  ooo_pkg::index_t     read_index,
  output ooo_pkg::data_t      read_data,
  output logic                read_error,
  output logic                empty
);

  import ooo_pkg::*;

  // Slot storage for payload words
  data_t memory [`OOO_DEPTH];

  // One valid bit per slot
  slot_mask_t valid;
  slot_mask_t valid_next;

  // Lowest free slot as one-hot and as binary index
  slot_mask_t free_onehot;
  index_t     free_index;

  // Registered status flags
  logic full_reg;
  logic empty_reg;

  // Read strobe that also frees the slot
  logic clear_strobe;

  // Allocation search over the current mask
  free_slot_finder slot_finder (
    .valid       ( valid       ),
    .free_onehot ( free_onehot ),
    .free_index  ( free_index  )
  );

  // Arbiter sees the slot before it commits the write
  assign wr.write_index = free_index;
  assign wr.full        = full_reg;

  assign clear_strobe = read_enable && read_clear;

  // Next valid mask
  // A write fills a free slot and a clear empties a valid one
  // so the two never meet on one slot
  always_comb begin
    valid_next = valid;
    if (wr.write_enable) begin
      valid_next = valid_next | free_onehot;
    end
    // Clear of a free slot does nothing, even while that slot is being filled
    if (clear_strobe && valid[read_index]) begin
      valid_next[read_index] = 1'b0;
    end
  end

  // Valid mask and status registers
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      valid     <= '0;
      full_reg  <= 1'b0;
      empty_reg <= 1'b1;
    end else begin
      valid     <= valid_next;
      // Flags reflect the mask that is valid after this edge
      full_reg  <= &valid_next;
      empty_reg <= ~|valid_next;
    end
  end

  // Payload write into the allocated slot
  always_ff @(posedge clock) begin
    if (wr.write_enable) begin
      memory[free_index] <= wr.write_data;
    end
  end

  // Combinational read
  // Stale data of a free slot is marked by read_error
  assign read_data = memory[read_index];

  // Error only while a read is actually requested
  assign read_error = read_enable && !valid[read_index];

  assign empty = empty_reg;

endmodule

`default_nettype wire

// ==== hdl/write_arbiter.sv ====
// Combinational round-robin grant; clients must hold request and data until they see a grant
`timescale 1ns/10ps
`default_nettype none

`include "ooo_defs.svh"

module write_arbiter (
  input  logic                                    clock,
  input  logic                                    resetn,
  input  ooo_pkg::client_mask_t                   write_request,
  input  ooo_pkg::data_t [`OOO_CLIENTS-1:0]       client_data,
  output ooo_pkg::client_mask_t                   write_grant,
  output ooo_pkg::index_t                         grant_index,
  buffer_write_if.arbiter                         wr
);

  import ooo_pkg::*;

  // Width of a client number, at least one bit
  localparam int CLIENT_BITS = (`OOO_CLIENTS > 1) ? $clog2(`OOO_CLIENTS) : 1;

  // Client that holds first priority this cycle
  logic [CLIENT_BITS-1:0] rr_pointer;
  logic [CLIENT_BITS-1:0] rr_pointer_next;

  // Search result
  logic [CLIENT_BITS-1:0] winner;
  logic                   request_found;

  // Client number under test in the rotated scan
  int candidate;

  // Grant is live only when the buffer has room
  logic grant_valid;

  // Rotated scan starting at the pointer
  // First requesting client wins
  always_comb begin
    request_found = 1'b0;
    winner        = '0;
    candidate     = 0;
    for (int offset = 0; offset < `OOO_CLIENTS; offset++) begin
      candidate = (int'(rr_pointer) + offset) % `OOO_CLIENTS;
      if (!request_found && write_request[candidate]) begin
        request_found = 1'b1;
        winner        = CLIENT_BITS'(candidate);
      end
    end
  end

  // Full blocks every grant, requests just stay pending
  assign grant_valid = request_found && !wr.full;

  // One-hot grant pulse
  assign write_grant = grant_valid ? (client_mask_t'(1) << winner) : '0;

  // Write strobe and steered data
  assign wr.write_enable = grant_valid;
  assign wr.write_data   = client_data[winner];

  // Slot number returned with the grant
  assign grant_index = wr.write_index;

  // Just past the winner, wrapping at the last client
  always_comb begin
    if (winner == CLIENT_BITS'(`OOO_CLIENTS - 1)) begin
      rr_pointer_next = '0;
    end else begin
      rr_pointer_next = winner + 1'b1;
    end
  end

  // Pointer only moves on a real grant
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      rr_pointer <= '0;
    end else if (grant_valid) begin
      rr_pointer <= rr_pointer_next;
    end
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+hdl
hdl/ooo_pkg.sv
hdl/buffer_write_if.sv
hdl/free_slot_finder.sv
hdl/out_of_order_buffer.sv
hdl/write_arbiter.sv
hdl/ooo_store_top.sv
tests/ooo_store_asserts.sv
tests/ooo_store_tb.sv

// ==== tests/ooo_store_asserts.sv ====
// Binds to ooo_store_top and checks it against a shadow model built only from its ports
`timescale 1ns/10ps
`default_nettype none

`include "ooo_defs.svh"

module ooo_store_asserts (
  input logic                              clock,
  input logic                              resetn,
  input ooo_pkg::client_mask_t             write_request,
  input ooo_pkg::data_t [`OOO_CLIENTS-1:0] client_data,
  input ooo_pkg::client_mask_t             write_grant,
  input ooo_pkg::index_t                   grant_index,
  input logic                              read_enable,
  input logic                              read_clear,
  input ooo_pkg::index_t                   read_index,
  input ooo_pkg::data_t                    read_data,
  input logic                              read_error,
  input logic                              full,
  input logic                              empty
);

  import ooo_pkg::*;

  // Details of the latest failure for the testbench
  int unsigned error_count = 0;
  string       fail_name = "";
  int unsigned fail_expected = 0;
  int unsigned fail_actual = 0;

  // Shadow of the slot store
  slot_mask_t shadow_valid;
  data_t      shadow_data [`OOO_DEPTH];

  // Client expected to hold first priority
  int rr_expect;

  // Expected values derived from the shadow
  index_t       free_expected;
  client_mask_t grant_expected;
  data_t        data_expected;
  logic         valid_at_read;
  logic         full_expected;
  logic         empty_expected;
  int           granted_client;
  slot_mask_t   set_mask;
  slot_mask_t   clear_mask;

  // Lowest clear bit of the mask
  // The scan runs downward so the lowest hit is kept last
  function automatic index_t lowest_free(input slot_mask_t mask);
    index_t result;
    result = '0;
    for (int slot = `OOO_DEPTH - 1; slot >= 0; slot--) begin
      if (!mask[slot]) begin
        result = index_t'(slot);
      end
    end
    return result;
  endfunction

  // First requester at or after the pointer
  // No grant is expected while full
  function automatic client_mask_t expected_pick(input client_mask_t request,
                                                 input int pointer, input logic is_full);
    client_mask_t pick;
    int           client;
    pick = '0;
    if (!is_full) begin
      for (int step = `OOO_CLIENTS - 1; step >= 0; step--) begin
        client = (pointer + step) % `OOO_CLIENTS;
        if (request[client]) begin
          pick = client_mask_t'(1) << client;
        end
      end
    end
    return pick;
  endfunction

  task automatic record_failure(input string name, input int unsigned expected,
                                input int unsigned actual);
    fail_name     = name;
    fail_expected = expected;
    fail_actual   = actual;
    error_count   = error_count + 1;
  endtask

  assign free_expected  = lowest_free(shadow_valid);
  assign full_expected  = &shadow_valid;
  assign empty_expected = ~|shadow_valid;
  assign grant_expected = expected_pick(write_request, rr_expect, full_expected);
  assign data_expected  = shadow_data[read_index];
  assign valid_at_read  = shadow_valid[read_index];

  // Granted client number taken from the port
  always_comb begin
    granted_client = 0;
    for (int client = 0; client < `OOO_CLIENTS; client++) begin
      if (write_grant[client]) begin
        granted_client = client;
      end
    end
  end

  assign set_mask   = (|write_grant) ? (slot_mask_t'(1) << free_expected) : '0;
  // A clear only frees a slot that holds data
  assign clear_mask = (read_enable && read_clear && valid_at_read) ?
                      (slot_mask_t'(1) << read_index) : '0;

  // Shadow valid mask and priority pointer
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      shadow_valid <= '0;
      rr_expect    <= 0;
    end else begin
      shadow_valid <= (shadow_valid | set_mask) & ~clear_mask;
      if (|write_grant) begin
        rr_expect <= (granted_client + 1) % `OOO_CLIENTS;
      end
    end
  end

  // Shadow payload
  always_ff @(posedge clock) begin
    if (|write_grant) begin
      shadow_data[free_expected] <= client_data[granted_client];
    end
  end

  allocation_check: assert property (@(posedge clock) disable iff (!resetn)
    (|write_grant) |-> (grant_index == free_expected))
  else begin
    record_failure("allocation", $sampled(free_expected), $sampled(grant_index));
    $error("granted slot is not the lowest free slot");
  end

  // Also covers the blocked grant while full
  round_robin_check: assert property (@(posedge clock) disable iff (!resetn)
    write_grant == grant_expected)
  else begin
    record_failure("round_robin", $sampled(grant_expected), $sampled(write_grant));
    $error("grant does not follow the round-robin turn");
  end

  grant_onehot_check: assert property (@(posedge clock) disable iff (!resetn)
    $onehot0(write_grant))
  else begin
    record_failure("grant_onehot", $sampled(grant_expected), $sampled(write_grant));
    $error("more than one grant in a cycle");
  end

  readback_check: assert property (@(posedge clock) disable iff (!resetn)
    (read_enable && valid_at_read) |-> (read_data == data_expected))
  else begin
    record_failure("readback", $sampled(data_expected), $sampled(read_data));
    $error("read data differs from the stored word");
  end

  // Low whenever no read is requested
  read_error_check: assert property (@(posedge clock) disable iff (!resetn)
    read_error == (read_enable && !valid_at_read))
  else begin
    record_failure("read_error", $sampled(read_enable && !valid_at_read),
                   $sampled(read_error));
    $error("read error flag is wrong");
  end

  full_check: assert property (@(posedge clock) disable iff (!resetn)
    full == full_expected)
  else begin
    record_failure("full_flag", $sampled(full_expected), $sampled(full));
    $error("full flag does not match the slot mask");
  end

  empty_check: assert property (@(posedge clock) disable iff (!resetn)
    empty == empty_expected)
  else begin
    record_failure("empty_flag", $sampled(empty_expected), $sampled(empty));
    $error("empty flag does not match the slot mask");
  end

endmodule

`default_nettype wire

// ==== tests/ooo_store_tb.sv ====
// Runs two rounds of fill, back-pressure and random drain and leaves every value check to the bound checker
`timescale 1ns/10ps
`default_nettype none

`include "ooo_defs.svh"

module ooo_store_tb;

  import ooo_pkg::*;

  // Run limit at about four times the stimulus length
  localparam int CYCLE_LIMIT = 600;

  logic                     clock;
  logic                     resetn;
  client_mask_t             write_request;
  data_t [`OOO_CLIENTS-1:0] client_data;
  client_mask_t             write_grant;
  index_t                   grant_index;
  logic                     read_enable;
  logic                     read_clear;
  index_t                   read_index;
  data_t                    read_data;
  logic                     read_error;
  logic                     full;
  logic                     empty;

  int cycle_count = 0;

  // Slot visiting order for readback and drain
  int order [`OOO_DEPTH];

  ooo_store_top uut (
    .clock         ( clock         ),
    .resetn        ( resetn        ),
    .write_request ( write_request ),
    .client_data   ( client_data   ),
    .write_grant   ( write_grant   ),
    .grant_index   ( grant_index   ),
    .read_enable   ( read_enable   ),
    .read_clear    ( read_clear    ),
    .read_index    ( read_index    ),
    .read_data     ( read_data     ),
    .read_error    ( read_error    ),
    .full          ( full          ),
    .empty         ( empty         )
  );

  bind ooo_store_top ooo_store_asserts checks (.*);

  initial begin
    clock = 1'b0;
    forever begin
      #10 clock = ~clock;
    end
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
      $display("Done: errors found");
      $fatal(1, "timeout");
    end
  end

  // Stop at the first assertion failure
  always @(uut.checks.error_count) begin
    if (uut.checks.error_count != 0) begin
      $display("FAIL %s expected %0h actual %0h", uut.checks.fail_name,
               uut.checks.fail_expected, uut.checks.fail_actual);
      $display("Done: errors found");
      $fatal(1, "assertion failure");
    end
  end

  // New word for every client that was just granted
  task automatic refresh_data(input client_mask_t granted);
    for (int client = 0; client < `OOO_CLIENTS; client++) begin
      if (granted[client]) begin
        client_data[client] = data_t'($urandom);
      end
    end
  endtask

  // Hold requests until count grants have been seen
  task automatic write_words(input client_mask_t mask, input int count);
    int           granted;
    client_mask_t seen;
    granted = 0;
    seen = '0;
    while (granted < count) begin
      @(negedge clock);
      refresh_data(seen);
      write_request = mask;
      // Grant is combinational and sampled mid low phase
      #5;
      seen = write_grant;
      if (seen != '0) begin
        granted++;
      end
    end
    @(negedge clock);
    refresh_data(seen);
    write_request = '0;
  endtask

  // Requests held against a full buffer
  task automatic hold_requests(input client_mask_t mask, input int cycles);
    @(negedge clock);
    write_request = mask;
    repeat (cycles) @(negedge clock);
    write_request = '0;
  endtask

  // One-cycle read followed by a released cycle
  task automatic read_slot(input int slot, input logic clear);
    @(negedge clock);
    read_enable = 1'b1;
    read_clear  = clear;
    read_index  = index_t'(slot);
    @(negedge clock);
    read_enable = 1'b0;
    read_clear  = 1'b0;
  endtask

  task automatic shuffle_order();
    int pick;
    int held;
    for (int i = 0; i < `OOO_DEPTH; i++) begin
      order[i] = i;
    end
    for (int i = `OOO_DEPTH - 1; i > 0; i--) begin
      pick = $urandom_range(i);
      held = order[i];
      order[i] = order[pick];
      order[pick] = held;
    end
  endtask

  task automatic fill_drain_round();
    int slot;
    // Single clients into an empty buffer land in slots 0 and 1
    write_words(client_mask_t'(1), 1);
    write_words(client_mask_t'(1) << 1, 1);
    read_slot(0, 1'b0);
    read_slot(1, 1'b0);
    // Both clients compete until full and then stay blocked
    write_words('1, `OOO_DEPTH - 2);
    hold_requests('1, 4);
    shuffle_order();
    for (int i = 0; i < `OOO_DEPTH; i++) begin
      read_slot(order[i], 1'b0);
    end
    // Freed slot comes back on the next grant
    slot = $urandom_range(`OOO_DEPTH - 1);
    read_slot(slot, 1'b1);
    write_words('1, 1);
    // Read and clear of a free slot
    slot = $urandom_range(`OOO_DEPTH - 1);
    read_slot(slot, 1'b1);
    read_slot(slot, 1'b0);
    read_slot(slot, 1'b1);
    // Clear of the free slot in the same cycle as its allocation
    fork
      read_slot(slot, 1'b1);
      write_words(client_mask_t'(1), 1);
    join
    // Out-of-order drain down to empty
    shuffle_order();
    for (int i = 0; i < `OOO_DEPTH; i++) begin
      read_slot(order[i], 1'b1);
    end
    read_slot($urandom_range(`OOO_DEPTH - 1), 1'b0);
  endtask

  initial begin
    void'($urandom(25618));
    resetn        = 1'b0;
    write_request = '0;
    client_data   = '0;
    read_enable   = 1'b0;
    read_clear    = 1'b0;
    read_index    = '0;
    refresh_data('1);
    repeat (2) @(posedge clock);
    @(negedge clock);
    resetn = 1'b1;
    // Idle cycles expose the reset state
    repeat (3) @(negedge clock);
    repeat (2) begin
      fill_drain_round();
    end
    repeat (3) @(negedge clock);
    if (uut.checks.error_count == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("Done: errors found");
      $fatal(1, "checks failed");
    end
  end

endmodule

`default_nettype wire
